// ==== design/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    //////////////////////////////
    // cache geometry
    //////////////////////////////
    localparam int offset_w   = 2;
    localparam int index_w    = 4;
    localparam int tag_w      = 32 - index_w - offset_w - 2;
    localparam int line_words = 4;
    localparam int num_sets   = 16;

    // controller state codes
    localparam logic [2:0] st_lookup   = 3'd0;
    localparam logic [2:0] st_miss_req = 3'd1;
    localparam logic [2:0] st_miss_wt  = 3'd2;
    localparam logic [2:0] st_wr_req   = 3'd3;
    localparam logic [2:0] st_wr_wt    = 3'd4;

    // one cache line, word 0 in the low bits
    typedef logic [line_words-1:0][31:0] line_t;

    // physical address seen raw or split into cache fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [tag_w-1:0]    tag;
            logic [index_w-1:0]  index;
            logic [offset_w-1:0] word;
            logic [1:0]          byte_off;
        } f;
    } dcache_addr_u;

endpackage

`default_nettype wire

// ==== design/dcache_req_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// buffered request, one writer and several readers
interface dcache_req_if import dcache_pkg::*; ();

    logic         valid;
    logic         we;
    dcache_addr_u addr;
    logic [31:0]  wdata;
    logic [3:0]   wstrb;

    modport rbuf (output valid, output we, output addr, output wdata, output wstrb);

    // FSM needs the op and the address for the memory side
    modport ctrl (input valid, input we, input addr);

    // tag and data arrays
    modport store (input addr, input wdata, input wstrb);

    // only the word offset matters here
    modport result (input addr);

endinterface

`default_nettype wire

// ==== design/dcache_rbuf.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_rbuf import dcache_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        req_valid,
    input  logic        req_ready,
    input  logic        req_we,
    input  logic [31:0] req_addr,
    input  logic [31:0] req_wdata,
    input  logic [3:0]  req_wstrb,
    input  logic        done,
    dcache_req_if.rbuf  rq
);

    logic accept;

    assign accept = req_valid && req_ready;

    // a new request wins over the done of the old one
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rq.valid <= 1'b0;
            rq.we    <= 1'b0;
        end else if (accept) begin
            rq.valid <= 1'b1;
            rq.we    <= req_we;
        end else if (done) begin
            rq.valid <= 1'b0;
        end
    end

    // address kept raw, readers use the field view
    always_ff @(posedge clk) begin
        if (accept) begin
            rq.addr.raw <= req_addr;
            rq.wdata    <= req_wdata;
            rq.wstrb    <= req_wstrb;
        end
    end

endmodule

`default_nettype wire

// ==== design/dcache_tagv.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tagv import dcache_pkg::*; (
    input  logic               clk,
    input  logic               arst_n,
    input  logic [index_w-1:0] rd_index,
    dcache_req_if.store        rq,
    input  logic               tag_we,
    input  logic               touch,
    output logic [1:0]         hit_way,
    output logic               victim
);

    logic [tag_w-1:0]          tag_mem [2][num_sets];
    logic [1:0][num_sets-1:0]  valid;
    logic [num_sets-1:0]       lru;
    logic [tag_w-1:0]          tag_q [2];
    logic [1:0]                valid_q;
    logic [index_w-1:0]        idx;
    logic                      used_way;

    assign idx = rq.addr.f.index;

    //////////////////////////////
    // tag array, early read
    //////////////////////////////
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            tag_q[w]   <= tag_mem[w][rd_index];
            valid_q[w] <= valid[w][rd_index];
        end
        if (tag_we) begin
            tag_mem[victim][idx] <= rq.addr.f.tag;
        end
    end

    // compare against the buffered tag
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit_way[w] = valid_q[w] && (tag_q[w] == rq.addr.f.tag);
        end
    end

    // empty way first, then lru
    always_comb begin
        if (!valid[0][idx]) begin
            victim = 1'b0;
        end else if (!valid[1][idx]) begin
            victim = 1'b1;
        end else begin
            victim = lru[idx];
        end
    end

    assign used_way = tag_we ? victim : hit_way[1];

    // lru bit names the next way to replace
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
            lru   <= '0;
        end else begin
            if (tag_we) begin
                valid[victim][idx] <= 1'b1;
            end
            if (touch) begin
                lru[idx] <= ~used_way;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/dcache_data.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_data import dcache_pkg::*; (
    input  logic               clk,
    input  logic [index_w-1:0] rd_index,
    dcache_req_if.store        rq,
    input  logic [1:0]         word_we,
    input  logic [1:0]         refill_we,
    input  line_t              refill_line,
    output line_t              line0,
    output line_t              line1
);

    line_t               mem [2][num_sets];
    line_t               rd_q [2];
    logic [index_w-1:0]  idx;
    logic [offset_w-1:0] wofs;

    assign idx  = rq.addr.f.index;
    assign wofs = rq.addr.f.word;

    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (refill_we[w]) begin
                mem[w][idx] <= refill_line;
            end else if (word_we[w]) begin
                // merge only the strobed bytes
                for (int b = 0; b < 4; b++) begin
                    if (rq.wstrb[b]) begin
                        mem[w][idx][wofs][8*b +: 8] <= rq.wdata[8*b +: 8];
                    end
                end
            end
            rd_q[w] <= mem[w][rd_index];
        end
    end

    assign line0 = rd_q[0];
    assign line1 = rd_q[1];

endmodule

`default_nettype wire

// ==== design/dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl import dcache_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    dcache_req_if.ctrl  rq,
    input  logic [1:0]  hit_way,
    input  logic        victim,
    input  logic        mem_addr_ok,
    input  logic        mem_data_ok,
    output logic        req_ready,
    output logic        mem_req,
    output logic        mem_wr,
    output logic [31:0] mem_addr,
    output logic        tag_we,
    output logic        touch,
    output logic [1:0]  word_we,
    output logic [1:0]  refill_we,
    output logic        done,
    output logic        resp_valid,
    output logic        from_refill
);

    logic [2:0] state;
    logic [2:0] state_n;
    logic       fin_q;
    logic       hit;
    logic       lookup;
    logic       go_mem;
    logic       fill;

    assign hit = |hit_way;

    // first cycle after acceptance
    assign lookup = (state == st_lookup) && rq.valid && !fin_q;
    assign go_mem = lookup && (rq.we || !hit);
    assign fill   = (state == st_miss_wt) && mem_data_ok;

    //////////////////////////////
    // pipeline side
    //////////////////////////////
    assign resp_valid  = (state == st_lookup) && rq.valid && (fin_q || (!rq.we && hit));
    assign done        = resp_valid;
    assign req_ready   = (state == st_lookup) && (!rq.valid || resp_valid);
    assign from_refill = fin_q && !rq.we;

    //////////////////////////////
    // memory side
    //////////////////////////////
    assign mem_req  = go_mem || (state == st_miss_req) || (state == st_wr_req);
    assign mem_wr   = rq.we;
    // reads fetch the whole line
    assign mem_addr = rq.we ? rq.addr.raw :
                      {rq.addr.raw[31:offset_w+2], {(offset_w+2){1'b0}}};

    // array updates
    assign word_we   = (lookup && rq.we) ? hit_way : 2'b00;
    assign tag_we    = fill;
    assign refill_we = fill ? {victim, ~victim} : 2'b00;
    assign touch     = fill || (lookup && hit);

    always_comb begin
        state_n = state;
        case (state)
            st_lookup: begin
                if (go_mem) begin
                    if (rq.we) begin
                        state_n = mem_addr_ok ? st_wr_wt : st_wr_req;
                    end else begin
                        state_n = mem_addr_ok ? st_miss_wt : st_miss_req;
                    end
                end
            end
            st_miss_req: if (mem_addr_ok) state_n = st_miss_wt;
            st_miss_wt:  if (mem_data_ok) state_n = st_lookup;
            st_wr_req:   if (mem_addr_ok) state_n = st_wr_wt;
            st_wr_wt:    if (mem_data_ok) state_n = st_lookup;
            default:     state_n = st_lookup;
        endcase
    end

    // fin_q marks the response cycle after a memory transaction
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_lookup;
            fin_q <= 1'b0;
        end else begin
            state <= state_n;
            fin_q <= ((state == st_miss_wt) || (state == st_wr_wt)) && mem_data_ok;
        end
    end

endmodule

`default_nettype wire

// ==== design/dcache_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_result import dcache_pkg::*; (
    input  logic         clk,
    dcache_req_if.result rq,
    input  logic [1:0]   hit_way,
    input  logic         from_refill,
    input  line_t        line0,
    input  line_t        line1,
    input  line_t        mem_rline,
    output logic [31:0]  resp_rdata
);

    line_t       hit_line;
    logic [31:0] fill_word;

    assign hit_line = (hit_way == 2'b10) ? line1 : line0;

    // tracks the memory line until the response cycle, then holds
    always_ff @(posedge clk) begin
        if (!from_refill) begin
            fill_word <= mem_rline[rq.addr.f.word];
        end
    end

    assign resp_rdata = from_refill ? fill_word : hit_line[rq.addr.f.word];

endmodule

`default_nettype wire

// ==== design/dcache_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_top import dcache_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    // pipeline side
    input  logic        req_valid,
    output logic        req_ready,
    input  logic        req_we,
    input  logic [31:0] req_addr,
    input  logic [31:0] req_wdata,
    input  logic [3:0]  req_wstrb,
    output logic        resp_valid,
    output logic [31:0] resp_rdata,
    // memory side
    output logic        mem_req,
    output logic        mem_wr,
    output logic [31:0] mem_addr,
    output logic [31:0] mem_wdata,
    output logic [3:0]  mem_wstrb,
    input  logic        mem_addr_ok,
    input  logic        mem_data_ok,
    input  line_t       mem_rline
);

    dcache_addr_u req_addr_u;
    logic [1:0]   hit_way;
    logic         victim;
    logic         tag_we;
    logic         touch;
    logic [1:0]   word_we;
    logic [1:0]   refill_we;
    logic         done;
    logic         from_refill;
    line_t        line0;
    line_t        line1;

    dcache_req_if rq ();

    // arrays are read at the incoming index
    assign req_addr_u = req_addr;

    // write-through data straight from the buffer
    assign mem_wdata = rq.wdata;
    assign mem_wstrb = rq.wstrb;

    dcache_rbuf u_rbuf (
        .clk(clk), .arst_n(arst_n), .req_valid(req_valid), .req_ready(req_ready),
        .req_we(req_we), .req_addr(req_addr), .req_wdata(req_wdata),
        .req_wstrb(req_wstrb), .done(done), .rq(rq.rbuf)
    );

    dcache_tagv u_tagv (
        .clk(clk), .arst_n(arst_n), .rd_index(req_addr_u.f.index), .rq(rq.store),
        .tag_we(tag_we), .touch(touch), .hit_way(hit_way), .victim(victim)
    );

    dcache_data u_data (
        .clk(clk), .rd_index(req_addr_u.f.index), .rq(rq.store), .word_we(word_we),
        .refill_we(refill_we), .refill_line(mem_rline), .line0(line0), .line1(line1)
    );

    dcache_ctrl u_ctrl (
        .clk(clk), .arst_n(arst_n), .rq(rq.ctrl), .hit_way(hit_way), .victim(victim),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok), .req_ready(req_ready),
        .mem_req(mem_req), .mem_wr(mem_wr), .mem_addr(mem_addr), .tag_we(tag_we),
        .touch(touch), .word_we(word_we), .refill_we(refill_we), .done(done),
        .resp_valid(resp_valid), .from_refill(from_refill)
    );

    dcache_result u_result (
        .clk(clk), .rq(rq.result), .hit_way(hit_way), .from_refill(from_refill),
        .line0(line0), .line1(line1), .mem_rline(mem_rline), .resp_rdata(resp_rdata)
    );

endmodule

`default_nettype wire

// ==== tb/mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

// line-wide memory with random handshake delays
module mem_model import dcache_pkg::*; (
    input  logic        clk,
    input  logic        mem_req,
    input  logic        mem_wr,
    input  logic [31:0] mem_addr,
    input  logic [31:0] mem_wdata,
    input  logic [3:0]  mem_wstrb,
    output logic        mem_addr_ok,
    output logic        mem_data_ok,
    output line_t       mem_rline
);

    logic [31:0] words [1024];
    logic [31:0] rnd;
    logic [31:0] a_q;
    logic [31:0] d_q;
    logic [3:0]  s_q;
    logic        wr_q;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // pattern depends on the full byte address
    function automatic logic [31:0] fill_pattern(input logic [31:0] a);
        return (a * 32'h9e3779b1) ^ 32'h5bd1e995;
    endfunction

    initial begin
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rline   = '0;
        rnd         = 32'h79aed66a ^ 32'h0000ffff;
        for (int i = 0; i < 1024; i++) begin
            words[i] = fill_pattern({20'b0, i[9:0], 2'b00});
        end
    end

    always begin
        @(negedge clk);
        if (mem_req) begin
            // hold off address acceptance
            rnd = xorshift(rnd);
            repeat (rnd % 3) begin
                @(posedge clk);
                #2;
            end
            @(posedge clk);
            #2 mem_addr_ok = 1'b1;
            @(negedge clk);
            a_q  = mem_addr;
            d_q  = mem_wdata;
            s_q  = mem_wstrb;
            wr_q = mem_wr;
            @(posedge clk);
            #2 mem_addr_ok = 1'b0;
            rnd = xorshift(rnd);
            repeat (rnd % 4) begin
                @(posedge clk);
                #2;
            end
            if (wr_q) begin
                for (int b = 0; b < 4; b++) begin
                    if (s_q[b]) begin
                        words[a_q[11:2]][8*b +: 8] = d_q[8*b +: 8];
                    end
                end
            end else begin
                for (int w = 0; w < line_words; w++) begin
                    mem_rline[w] = words[{a_q[11:4], w[1:0]}];
                end
            end
            mem_data_ok = 1'b1;
            @(posedge clk);
            #2 mem_data_ok = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== tb/dcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tb import dcache_pkg::*; ();

    localparam int n_random   = 200;
    localparam int n_req      = n_random + 16;
    // worst request is about 12 cycles
    localparam int timeout_ns = n_req * 20 * 40 + 20000;

    logic        clk;
    logic        arst_n;
    logic        req_valid;
    logic        req_ready;
    logic        req_we;
    logic [31:0] req_addr;
    logic [31:0] req_wdata;
    logic [3:0]  req_wstrb;
    logic        resp_valid;
    logic [31:0] resp_rdata;
    logic        mem_req;
    logic        mem_wr;
    logic [31:0] mem_addr;
    logic [31:0] mem_wdata;
    logic [3:0]  mem_wstrb;
    logic        mem_addr_ok;
    logic        mem_data_ok;
    line_t       mem_rline;

    // shadow model
    logic [31:0]      shadow [1024];
    logic [tag_w-1:0] s_tag [num_sets][2];
    logic             s_val [num_sets][2];
    logic             s_lru [num_sets];

    // memory transactions seen since the request started
    logic        mq_wr [$];
    logic [31:0] mq_addr [$];
    logic [31:0] mq_wdata [$];
    logic [3:0]  mq_wstrb [$];

    int          errors;
    int          tests;
    int          failed;
    int          err_mark;
    logic [31:0] seed;
    logic [31:0] r;

    dcache_top u_dut (.*);

    mem_model u_mem (
        .clk(clk), .mem_req(mem_req), .mem_wr(mem_wr), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_wstrb(mem_wstrb), .mem_addr_ok(mem_addr_ok),
        .mem_data_ok(mem_data_ok), .mem_rline(mem_rline)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] fill_pattern(input logic [31:0] a);
        return (a * 32'h9e3779b1) ^ 32'h5bd1e995;
    endfunction

    always @(negedge clk) begin
        if (mem_req && mem_addr_ok) begin
            mq_wr.push_back(mem_wr);
            mq_addr.push_back(mem_addr);
            mq_wdata.push_back(mem_wdata);
            mq_wstrb.push_back(mem_wstrb);
        end
    end

    //////////////////////////////
    // one request, predicted and checked
    //////////////////////////////
    task automatic run_req(input string name, input logic we, input logic [31:0] addr,
                           input logic [31:0] wdata, input logic [3:0] strb);
        int          set;
        int          hw;
        int          vic;
        logic [31:0] exp;
        logic [31:0] exp_maddr;
        set = addr[7:4];
        hw  = -1;
        for (int w = 0; w < 2; w++) begin
            if (s_val[set][w] && s_tag[set][w] == addr[31:8]) begin
                hw = w;
            end
        end
        exp       = shadow[addr[11:2]];
        exp_maddr = we ? addr : {addr[31:4], 4'b0000};
        if (hw >= 0) begin
            s_lru[set] = (hw == 0);
        end else if (!we) begin
            vic = !s_val[set][0] ? 0 : (!s_val[set][1] ? 1 : int'(s_lru[set]));
            s_val[set][vic] = 1'b1;
            s_tag[set][vic] = addr[31:8];
            s_lru[set]      = (vic == 0);
        end
        if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    shadow[addr[11:2]][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end
        @(posedge clk);
        #2;
        mq_wr.delete();
        mq_addr.delete();
        mq_wdata.delete();
        mq_wstrb.delete();
        req_valid = 1'b1;
        req_we    = we;
        req_addr  = addr;
        req_wdata = wdata;
        req_wstrb = strb;
        @(negedge clk);
        assert (!resp_valid) else begin
            errors++;
            $display("%s: response seen before the request was accepted", name);
        end
        while (!req_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #2 req_valid = 1'b0;
        @(negedge clk);
        if (!we && hw >= 0) begin
            assert (resp_valid) else begin
                errors++;
                $display("%s: load hit gave no response one cycle after acceptance", name);
            end
        end
        while (!resp_valid) begin
            assert (!req_ready) else begin
                errors++;
                $display("%s: req_ready high while a memory access is pending", name);
            end
            @(negedge clk);
        end
        if (!we) begin
            assert (resp_rdata == exp) else begin
                errors++;
                $display("Mismatch %s: expected %h actual %h", name, exp, resp_rdata);
            end
        end
        if (!we && hw >= 0) begin
            assert (!mem_req && req_ready) else begin
                errors++;
                $display("%s: load hit requested memory or held off the next request", name);
            end
        end else begin
            assert (mq_addr.size() == 1) else begin
                errors++;
                $display("%s: expected one memory access, saw %0d", name, mq_addr.size());
            end
            if (mq_addr.size() == 1) begin
                assert (mq_wr[0] == we && mq_addr[0] == exp_maddr) else begin
                    errors++;
                    $display("Mismatch %s: expected wr %b addr %h actual wr %b addr %h",
                             name, we, exp_maddr, mq_wr[0], mq_addr[0]);
                end
                assert (!we || (mq_wdata[0] == wdata && mq_wstrb[0] == strb)) else begin
                    errors++;
                    $display("Mismatch %s: expected %h/%b actual %h/%b", name, wdata, strb,
                             mq_wdata[0], mq_wstrb[0]);
                end
            end
        end
    endtask

    task automatic close_test(input string name);
        tests++;
        if (errors == err_mark) begin
            $display("test %s passed", name);
        end else begin
            failed++;
            $display("test %s failed", name);
        end
        err_mark = errors;
    endtask

    initial begin
        #(timeout_ns);
        $display("watchdog expired before all tests finished");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        clk       = 1'b0;
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req_we    = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        req_wstrb = '0;
        errors    = 0;
        tests     = 0;
        failed    = 0;
        err_mark  = 0;
        seed      = 32'h79aed66a;
        for (int i = 0; i < 1024; i++) begin
            shadow[i] = fill_pattern({20'b0, i[9:0], 2'b00});
        end
        for (int s = 0; s < num_sets; s++) begin
            s_val[s][0] = 1'b0;
            s_val[s][1] = 1'b0;
            s_lru[s]    = 1'b0;
        end
        repeat (2) @(posedge clk);
        #2 arst_n = 1'b1;

        repeat (3) begin
            @(negedge clk);
            assert (req_ready && !resp_valid && !mem_req) else begin
                errors++;
                $display("reset: handshake outputs wrong before the first request");
            end
        end
        close_test("reset");

        run_req("miss_then_hit", 1'b0, 32'h410, '0, '0);
        run_req("miss_then_hit", 1'b0, 32'h418, '0, '0);
        close_test("miss_then_hit");

        run_req("store_hit", 1'b1, 32'h414, 32'hdeadbeef, 4'b0110);
        run_req("store_hit", 1'b0, 32'h414, '0, '0);
        run_req("store_hit", 1'b1, 32'h41c, 32'h12345678, 4'b1000);
        run_req("store_hit", 1'b0, 32'h41c, '0, '0);
        close_test("store_hit");

        run_req("no_allocate", 1'b1, 32'h560, 32'hcafef00d, 4'b0011);
        run_req("no_allocate", 1'b0, 32'h560, '0, '0);
        close_test("no_allocate");

        // A, B and C all map to set 3
        run_req("replace", 1'b0, 32'h030, '0, '0);
        run_req("replace", 1'b0, 32'h130, '0, '0);
        run_req("replace", 1'b0, 32'h034, '0, '0);
        run_req("replace", 1'b0, 32'h230, '0, '0);
        run_req("replace", 1'b0, 32'h038, '0, '0);
        run_req("replace", 1'b0, 32'h134, '0, '0);
        close_test("replace");

        for (int i = 0; i < n_random; i++) begin
            seed = xorshift(seed);
            r    = seed;
            seed = xorshift(seed);
            run_req("random", r[0], {22'b0, r[9:2], 2'b00}, seed,
                    (r[13:10] == 4'b0000) ? 4'b1111 : r[13:10]);
        end
        close_test("random");

        $display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
design/dcache_pkg.sv
design/dcache_req_if.sv
design/dcache_rbuf.sv
design/dcache_tagv.sv
design/dcache_data.sv
design/dcache_ctrl.sv
design/dcache_result.sv
design/dcache_top.sv
tb/mem_model.sv
tb/dcache_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cache testbench with Verilator
verilator --binary --timing --assert -Wno-fatal --top-module dcache_tb -f tb.f \
    -o sim_dcache > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/sim_dcache > sim.log 2>&1 || true
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || grep -q "STATUS: PASS" sim.log
